//--- video_out_pkg.sv
// Shared types and constants for the video output path
// The raster is a reduced test raster, not a standard video timing
// Colour coefficients are BT.601 studio range, scaled by 256
package video_out_pkg;

  typedef logic [7:0]         chan_t;
  typedef logic [15:0]        txd_t;
  typedef logic [5:0]         hcount_t;
  typedef logic [3:0]         vcount_t;
  typedef logic signed [8:0]  coef_t;
  typedef logic signed [17:0] prod_t;

  // r in the top byte
  typedef struct packed {
    chan_t r;
    chan_t g;
    chan_t b;
  } rgb_pix_t;

  typedef struct packed {
    chan_t y;
    chan_t cb;
    chan_t cr;
  } ycbcr_pix_t;

  // All active high
  typedef struct packed {
    logic vsync;
    logic hsync;
    logic de;
  } video_sync_t;

  typedef struct packed {
    video_sync_t sync;
    txd_t        txd;
  } hdmi_out_t;

  //////////////////////////////////////////////////
  // Raster, active video first in each line and frame
  //////////////////////////////////////////////////
  localparam hcount_t H_ACTIVE     = 6'd32;
  localparam hcount_t H_FRONT      = 6'd4;
  localparam hcount_t H_SYNC       = 6'd4;
  localparam hcount_t H_BACK       = 6'd8;
  localparam hcount_t H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam hcount_t H_SYNC_START = H_ACTIVE + H_FRONT;
  localparam hcount_t H_SYNC_END   = H_SYNC_START + H_SYNC;

  localparam vcount_t V_ACTIVE     = 4'd4;
  localparam vcount_t V_FRONT      = 4'd1;
  localparam vcount_t V_SYNC       = 4'd1;
  localparam vcount_t V_BACK       = 4'd2;
  localparam vcount_t V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam vcount_t V_SYNC_START = V_ACTIVE + V_FRONT;
  localparam vcount_t V_SYNC_END   = V_SYNC_START + V_SYNC;

  // 384 cycles per frame
  localparam int FRAME_CYCLES = int'(H_TOTAL) * int'(V_TOTAL);

  //////////////////////////////////////////////////
  // BT.601 conversion
  //////////////////////////////////////////////////
  localparam coef_t Y_R  = 9'sd66;
  localparam coef_t Y_G  = 9'sd129;
  localparam coef_t Y_B  = 9'sd25;
  localparam coef_t CB_R = -9'sd38;
  localparam coef_t CB_G = -9'sd74;
  localparam coef_t CB_B = 9'sd112;
  localparam coef_t CR_R = 9'sd112;
  localparam coef_t CR_G = -9'sd94;
  localparam coef_t CR_B = -9'sd18;

  localparam prod_t ROUND    = 18'sd128;
  localparam int    SHIFT    = 8;
  localparam prod_t Y_OFFSET = 18'sd16;
  localparam prod_t C_OFFSET = 18'sd128;

  // Converts to Y 16, Cb 128, Cr 128
  localparam rgb_pix_t BLACK_PIX = '0;

endpackage

//--- video_timing_gen.sv
// Raster timing for the reduced test raster in video_out_pkg
// Syncs and display enable are decoded combinationally from the counters
// Counters sit on the last raster position during reset, so the first
// cycle after reset release is still blank and the next one is h 0, v 0
`timescale 1ns/1ps

module video_timing_gen (
  input  logic                       video_clk_148,
  input  logic                       video_reset_148,
  output video_out_pkg::video_sync_t o_sync
);

  import video_out_pkg::*;

  hcount_t hcount;
  vcount_t vcount;
  logic    h_last;
  logic    v_last;

  assign h_last = (hcount == H_TOTAL - 6'd1);
  assign v_last = (vcount == V_TOTAL - 4'd1);

  //////////////////////////////////////////////////
  // Pixel and line counters
  //////////////////////////////////////////////////
  always_ff @(posedge video_clk_148)
  begin
    if (video_reset_148)
    begin
      // Park in back porch so de stays low out of reset
      hcount <= H_TOTAL - 6'd1;
      vcount <= V_TOTAL - 4'd1;
    end
    else if (h_last)
    begin
      hcount <= '0;
      if (v_last)
      begin
        vcount <= '0;
      end
      else
      begin
        vcount <= vcount + 4'd1;
      end
    end
    else
    begin
      hcount <= hcount + 6'd1;
    end
  end

  //////////////////////////////////////////////////
  // Sync decode
  //////////////////////////////////////////////////

  // Active area is the top left corner of the raster
  assign o_sync.de = (hcount < H_ACTIVE) && (vcount < V_ACTIVE);

  // Line sync after front porch
  assign o_sync.hsync = (hcount >= H_SYNC_START) && (hcount < H_SYNC_END);

  // Frame sync covers whole lines
  assign o_sync.vsync = (vcount >= V_SYNC_START) && (vcount < V_SYNC_END);

endmodule

//--- pixel_fetch.sv
// Pulls one RGB pixel per display-enable cycle from a ready/valid stream
// Ready follows display enable; the stream is never allowed to stall video
// A missing pixel is replaced by black and reported on o_underflow
`timescale 1ns/1ps

module pixel_fetch (
  input  logic                       video_clk_148,
  input  logic                       video_reset_148,
  input  video_out_pkg::video_sync_t i_sync,
  input  video_out_pkg::rgb_pix_t    i_pix_data,
  input  logic                       i_pix_valid,
  output logic                       o_pix_ready,
  output video_out_pkg::rgb_pix_t    o_pix,
  output video_out_pkg::video_sync_t o_sync,
  output logic                       o_underflow
);

  import video_out_pkg::*;

  logic take_pix;

  // Accept only inside the active window
  assign o_pix_ready = i_sync.de;
  assign take_pix    = i_sync.de && i_pix_valid;

  // Syncs and underflow flag
  always_ff @(posedge video_clk_148)
  begin
    if (video_reset_148)
    begin
      o_sync      <= '0;
      o_underflow <= 1'b0;
    end
    else
    begin
      o_sync      <= i_sync;
      // One pulse per missed active cycle
      o_underflow <= i_sync.de && !i_pix_valid;
    end
  end

  // Pixel register, black in blanking and on a miss
  always_ff @(posedge video_clk_148)
  begin
    if (take_pix)
    begin
      o_pix <= i_pix_data;
    end
    else
    begin
      o_pix <= BLACK_PIX;
    end
  end

endmodule

//--- rgb_to_ycbcr.sv
// Three-stage BT.601 RGB to YCbCr conversion, 8 bits per channel
// Stage one multiplies, stage two sums with rounding, stage three scales,
// adds the offsets and clips to 0..255
// Syncs are delayed by three cycles to stay aligned with the data
`timescale 1ns/1ps

module rgb_to_ycbcr (
  input  logic                       video_clk_148,
  input  logic                       video_reset_148,
  input  video_out_pkg::rgb_pix_t    i_pix,
  input  video_out_pkg::video_sync_t i_sync,
  output video_out_pkg::ycbcr_pix_t  o_pix,
  output video_out_pkg::video_sync_t o_sync
);

  import video_out_pkg::*;

  // Products indexed 2 r, 1 g, 0 b
  prod_t [2:0]       y_prod;
  prod_t [2:0]       cb_prod;
  prod_t [2:0]       cr_prod;
  prod_t             y_sum;
  prod_t             cb_sum;
  prod_t             cr_sum;
  video_sync_t [2:0] sync_pipe;

  // Unsigned channel times signed coefficient
  function automatic prod_t mult(chan_t c, coef_t k);
    return prod_t'($signed({1'b0, c})) * prod_t'(k);
  endfunction

  // Arithmetic shift keeps negative chroma sums correct
  function automatic chan_t scale_clip(prod_t sum, prod_t offset);
    prod_t v;
    v = (sum >>> SHIFT) + offset;
    if (v < prod_t'(0))
      return 8'd0;
    if (v > prod_t'(255))
      return 8'd255;
    return chan_t'(v);
  endfunction

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////
  always_ff @(posedge video_clk_148)
  begin
    // Stage one
    y_prod[2]  <= mult(i_pix.r, Y_R);
    y_prod[1]  <= mult(i_pix.g, Y_G);
    y_prod[0]  <= mult(i_pix.b, Y_B);
    cb_prod[2] <= mult(i_pix.r, CB_R);
    cb_prod[1] <= mult(i_pix.g, CB_G);
    cb_prod[0] <= mult(i_pix.b, CB_B);
    cr_prod[2] <= mult(i_pix.r, CR_R);
    cr_prod[1] <= mult(i_pix.g, CR_G);
    cr_prod[0] <= mult(i_pix.b, CR_B);

    // Stage two
    y_sum  <= y_prod[2] + y_prod[1] + y_prod[0] + ROUND;
    cb_sum <= cb_prod[2] + cb_prod[1] + cb_prod[0] + ROUND;
    cr_sum <= cr_prod[2] + cr_prod[1] + cr_prod[0] + ROUND;

    // Stage three
    o_pix.y  <= scale_clip(y_sum, Y_OFFSET);
    o_pix.cb <= scale_clip(cb_sum, C_OFFSET);
    o_pix.cr <= scale_clip(cr_sum, C_OFFSET);
  end

  // Sync delay, one entry per datapath stage
  always_ff @(posedge video_clk_148)
  begin
    if (video_reset_148)
    begin
      sync_pipe <= '0;
    end
    else
    begin
      sync_pipe <= {sync_pipe[1:0], i_sync};
    end
  end

  assign o_sync = sync_pipe[2];

endmodule

//--- ycbcr422_packer.sv
// Packs 4:4:4 YCbCr into 4:2:2 on a 16-bit bus, chroma in the high byte
// Each line starts with Cb; chroma of the skipped phase is dropped,
// no horizontal filtering
`timescale 1ns/1ps

module ycbcr422_packer (
  input  logic                       video_clk_148,
  input  logic                       video_reset_148,
  input  video_out_pkg::ycbcr_pix_t  i_pix,
  input  video_out_pkg::video_sync_t i_sync,
  output video_out_pkg::hdmi_out_t   o_hdmi
);

  import video_out_pkg::*;

  // Low sends Cb, high sends Cr
  logic chroma_odd;

  //////////////////////////////////////////////////
  // Chroma phase
  //////////////////////////////////////////////////
  always_ff @(posedge video_clk_148)
  begin
    if (video_reset_148)
    begin
      chroma_odd <= 1'b0;
    end
    else if (i_sync.de)
    begin
      chroma_odd <= ~chroma_odd;
    end
    else
    begin
      // Blanking realigns the next line to Cb
      chroma_odd <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////
  always_ff @(posedge video_clk_148)
  begin
    if (video_reset_148)
    begin
      o_hdmi <= '0;
    end
    else
    begin
      o_hdmi.sync <= i_sync;
      if (!i_sync.de)
      begin
        o_hdmi.txd <= '0;
      end
      else if (chroma_odd)
      begin
        o_hdmi.txd <= {i_pix.cr, i_pix.y};
      end
      else
      begin
        o_hdmi.txd <= {i_pix.cb, i_pix.y};
      end
    end
  end

endmodule

//--- video_out_top.sv
// Video output path: timing, pixel fetch, colour conversion, 4:2:2 packing
// Reset must already be synchronous to video_clk_148
// Pixel to o_hdmi latency is 5 cycles; the stream cannot stall the display
`timescale 1ns/1ps

module video_out_top (
  input  logic                     video_clk_148,
  input  logic                     video_reset_148,
  input  video_out_pkg::rgb_pix_t  i_pix_data,
  input  logic                     i_pix_valid,
  output logic                     o_pix_ready,
  output video_out_pkg::hdmi_out_t o_hdmi,
  output logic                     o_underflow
);

  import video_out_pkg::*;

  video_sync_t timing_sync;
  rgb_pix_t    fetch_pix;
  video_sync_t fetch_sync;
  ycbcr_pix_t  ycc_pix;
  video_sync_t ycc_sync;

  //////////////////////////////////////////////////
  // Raster and stream side
  //////////////////////////////////////////////////
  video_timing_gen u_video_timing_gen (
    .video_clk_148   (video_clk_148),
    .video_reset_148 (video_reset_148),
    .o_sync          (timing_sync)
  );

  pixel_fetch u_pixel_fetch (
    .video_clk_148   (video_clk_148),
    .video_reset_148 (video_reset_148),
    .i_sync          (timing_sync),
    .i_pix_data      (i_pix_data),
    .i_pix_valid     (i_pix_valid),
    .o_pix_ready     (o_pix_ready),
    .o_pix           (fetch_pix),
    .o_sync          (fetch_sync),
    .o_underflow     (o_underflow)
  );

  //////////////////////////////////////////////////
  // Colour path
  //////////////////////////////////////////////////
  rgb_to_ycbcr u_rgb_to_ycbcr (
    .video_clk_148   (video_clk_148),
    .video_reset_148 (video_reset_148),
    .i_pix           (fetch_pix),
    .i_sync          (fetch_sync),
    .o_pix           (ycc_pix),
    .o_sync          (ycc_sync)
  );

  ycbcr422_packer u_ycbcr422_packer (
    .video_clk_148   (video_clk_148),
    .video_reset_148 (video_reset_148),
    .i_pix           (ycc_pix),
    .i_sync          (ycc_sync),
    .o_hdmi          (o_hdmi)
  );

endmodule

//--- tb_video_out.sv
// Testbench for video_out_top, records read from video_out_stimulus.txt
// Each record shows one colour for two frames; stall records drop valid at random
// Expected YCbCr comes from the file, and 16/128/128 on every missed pixel
`timescale 1ns/1ps

module tb_video_out;

  import video_out_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 10;
  localparam int REC_CYCLES   = 2 * FRAME_CYCLES;
  // Edges from the transfer edge to the o_hdmi register edge
  localparam int PIPE_EDGES   = 4;
  localparam ycbcr_pix_t BLACK_YCC = '{y: 8'd16, cb: 8'd128, cr: 8'd128};

  logic        video_clk_148;
  logic        video_reset_148;
  rgb_pix_t    i_pix_data;
  logic        i_pix_valid;
  logic        o_pix_ready;
  hdmi_out_t   o_hdmi;
  logic        o_underflow;

  rgb_pix_t    rec_rgb[$];
  ycbcr_pix_t  rec_ycc[$];
  bit          rec_stall[$];
  ycbcr_pix_t  pix_q[$];
  int          pix_due_q[$];
  int          uf_due_q[$];
  ycbcr_pix_t  cur_ycc;
  logic [31:0] rng;
  int          cyc = 0;
  bit          run_on = 1'b0;
  bit          loaded = 1'b0;
  int          errors = 0;
  int          transfers = 0;
  int          misses = 0;
  int          pulses = 0;
  int          de_len = 0;
  int          hs_len = 0;
  int          vs_len = 0;
  int          act_lines = 0;
  int          last_vs_rise = 0;
  bit          phase = 1'b0;
  video_sync_t prev_sync = '0;

  video_out_top u_video_out_top (
    .video_clk_148   (video_clk_148),
    .video_reset_148 (video_reset_148),
    .i_pix_data      (i_pix_data),
    .i_pix_valid     (i_pix_valid),
    .o_pix_ready     (o_pix_ready),
    .o_hdmi          (o_hdmi),
    .o_underflow     (o_underflow)
  );

  initial
  begin
    video_clk_148 = 1'b0;
    forever #(CLK_PERIOD / 2) video_clk_148 = ~video_clk_148;
  end

  always @(posedge video_clk_148)
    cyc <= cyc + 1;

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("ERROR at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic load_records();
    int         fd;
    int         n;
    string      line;
    logic [7:0] r, g, b, y, cb, cr, st;
    fd = $fopen("video_out_stimulus.txt", "r");
    if (fd != 0)
    begin
      while (!$feof(fd))
      begin
        n = $fgets(line, fd);
        if (n > 0 && line.getc(0) != "#")
        begin
          n = $sscanf(line, "%h %h %h %h %h %h %h", r, g, b, y, cb, cr, st);
          if (n == 7)
          begin
            rec_rgb.push_back({r, g, b});
            rec_ycc.push_back({y, cb, cr});
            rec_stall.push_back(st != 8'd0);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  //////////////////////////////////////////////////
  // Stream source
  //////////////////////////////////////////////////
  task automatic play_record(int idx);
    int err_start;
    int tr_start;
    int ms_start;
    err_start = errors;
    tr_start  = transfers;
    ms_start  = misses;
    for (int c = 0; c < REC_CYCLES; c++)
    begin
      @(posedge video_clk_148);
      i_pix_data <= rec_rgb[idx];
      cur_ycc    <= rec_ycc[idx];
      rng = xorshift32(rng);
      // Last cycle lands in blanking, so the colour can change behind it
      if (c == REC_CYCLES - 1)
        i_pix_valid <= 1'b0;
      else if (rec_stall[idx])
        i_pix_valid <= (rng[1:0] != 2'b00);
      else
        i_pix_valid <= 1'b1;
    end
    // Two frames of active video, each ready cycle transfers or misses
    check_value("o_pix_ready cycles", (transfers - tr_start) + (misses - ms_start),
                32'(2 * int'(V_ACTIVE) * int'(H_ACTIVE)));
    $display("test %0d rgb %h stall %0d: %0d transfers, %0d misses, %0d errors", idx,
             rec_rgb[idx], rec_stall[idx], transfers - tr_start, misses - ms_start,
             errors - err_start);
  endtask

  //////////////////////////////////////////////////
  // Reference model and output checks
  //////////////////////////////////////////////////
  task automatic track_input();
    if (run_on && o_pix_ready)
    begin
      if (i_pix_valid)
      begin
        pix_q.push_back(cur_ycc);
        transfers++;
      end
      else
      begin
        pix_q.push_back(BLACK_YCC);
        uf_due_q.push_back(cyc + 1);
        misses++;
      end
      pix_due_q.push_back(cyc + 1 + PIPE_EDGES);
    end
    if (run_on)
    begin
      if (o_underflow)
        pulses++;
      if (uf_due_q.size() > 0 && uf_due_q[0] == cyc)
      begin
        check_value("o_underflow", 32'(o_underflow), 32'd1);
        void'(uf_due_q.pop_front());
      end
      else
        check_value("o_underflow", 32'(o_underflow), 32'd0);
    end
  endtask

  task automatic check_output();
    ycbcr_pix_t exp;
    int         due;
    if (o_hdmi.sync.de)
    begin
      if (pix_q.size() == 0)
      begin
        assert (!run_on)
        else
        begin
          $display("Output word at %0d ns has no pixel in flight", $time);
          errors++;
        end
      end
      else
      begin
        exp = pix_q.pop_front();
        due = pix_due_q.pop_front();
        check_value("o_hdmi.sync.de cycle", cyc, due);
        // Cb on the first word of a line, then Cr and Cb in turn
        if (phase)
          check_value("o_hdmi.txd", 32'(o_hdmi.txd), 32'({exp.cr, exp.y}));
        else
          check_value("o_hdmi.txd", 32'(o_hdmi.txd), 32'({exp.cb, exp.y}));
      end
      phase = ~phase;
    end
    else
    begin
      check_value("o_hdmi.txd", 32'(o_hdmi.txd), 32'd0);
      phase = 1'b0;
    end
  endtask

  task automatic check_raster();
    video_sync_t s;
    s = o_hdmi.sync;
    if (s.de)
      de_len++;
    if (prev_sync.de && !s.de)
    begin
      check_value("o_hdmi.sync.de length", de_len, 32'(H_ACTIVE));
      act_lines++;
      de_len = 0;
    end
    if (s.hsync)
      hs_len++;
    if (prev_sync.hsync && !s.hsync)
    begin
      check_value("o_hdmi.sync.hsync length", hs_len, 32'(H_SYNC));
      hs_len = 0;
    end
    if (s.vsync)
      vs_len++;
    if (prev_sync.vsync && !s.vsync)
    begin
      check_value("o_hdmi.sync.vsync length", vs_len, 32'(int'(V_SYNC) * int'(H_TOTAL)));
      vs_len = 0;
    end
    if (s.vsync && !prev_sync.vsync)
    begin
      check_value("active lines per frame", act_lines, 32'(V_ACTIVE));
      if (last_vs_rise > 0)
        check_value("vsync period", cyc - last_vs_rise, 32'(int'(H_TOTAL) * int'(V_TOTAL)));
      act_lines    = 0;
      last_vs_rise = cyc;
    end
    prev_sync = s;
  endtask

  // Sampled on the falling edge, away from the driving edge
  always @(negedge video_clk_148)
  begin
    if (cyc > RESET_CYCLES)
    begin
      track_input();
      check_output();
      check_raster();
    end
  end

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////
  initial
  begin
    i_pix_data      = '0;
    i_pix_valid     = 1'b0;
    video_reset_148 = 1'b1;
    cur_ycc         = '0;
    rng             = 32'h56ec;
    load_records();
    loaded = 1'b1;
    if (rec_rgb.size() == 0)
    begin
      $display("No records could be read from video_out_stimulus.txt");
      $display("Testbench failed");
      $finish;
    end
    else
    begin
      for (int c = 0; c < RESET_CYCLES; c++)
      begin
        @(posedge video_clk_148);
        if (c == RESET_CYCLES - 1)
          video_reset_148 <= 1'b0;
        @(negedge video_clk_148);
        check_value("o_pix_ready", 32'(o_pix_ready), 32'd0);
        check_value("o_underflow", 32'(o_underflow), 32'd0);
        check_value("o_hdmi", 32'(o_hdmi), 32'd0);
      end
      $display("test reset: %0d errors", errors);
      run_on = 1'b1;
      for (int i = 0; i < rec_rgb.size(); i++)
        play_record(i);
      @(posedge video_clk_148);
      run_on = 1'b0;
      repeat (PIPE_EDGES + 2) @(posedge video_clk_148);
      check_value("o_underflow pulses", pulses, misses);
      assert (pix_q.size() == 0 && uf_due_q.size() == 0)
      else
      begin
        $display("Expected pixels or underflow pulses never appeared");
        errors++;
      end
      assert (misses > 0)
      else
      begin
        $display("Stall records produced no missed pixels");
        errors++;
      end
      $display("%0d tests, %0d transfers, %0d misses, %0d underflow pulses, %0d errors",
               rec_rgb.size() + 1, transfers, misses, pulses, errors);
      if (errors == 0)
        $display("Testbench passed");
      else
        $display("Testbench failed");
      $finish;
    end
  end

  initial
  begin
    int limit;
    wait (loaded);
    limit = 2 * rec_rgb.size() * REC_CYCLES * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;
    #(limit);
    $display("Watchdog expired at %0d ns before the tests finished", $time);
    $display("Testbench failed");
    $finish;
  end

endmodule

//--- video_out_stimulus.txt
# r g b y cb cr stall, all hex, one colour record per line
# stall 1 drops the stream valid at random during that record
00 00 00 10 80 80 0
ff ff ff eb 80 80 0
ff 00 00 52 5a f0 0
00 ff 00 90 36 22 0
00 00 ff 29 f0 6e 0
80 80 80 7e 80 80 0
40 a0 20 74 56 5f 0
ff ff 00 d2 10 92 1
00 ff ff a9 a6 10 1
ff 00 ff 6b ca de 1

//--- video_out.f
video_out_pkg.sv
video_timing_gen.sv
pixel_fetch.sv
rgb_to_ycbcr.sv
ycbcr422_packer.sv
video_out_top.sv
tb_video_out.sv

//--- Makefile
TOP := tb_video_out
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f video_out.f

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
		--top-module video_out_top -f video_out.f

clean:
	rm -rf obj_dir $(LOG)
